//--- smc_pkg.sv
package smc_pkg;

   // ------------------------------
   // Widths
   // ------------------------------
   localparam int smc_addr_w = 16;   // External address bus
   localparam int smc_data_w = 32;   // External data bus
   localparam int smc_be_w   = 4;    // Byte lanes
   localparam int smc_ws_w   = 8;    // Wait state count
   localparam int smc_edge_w = 2;    // Leading edge and read delay settings

   // Access states
   typedef enum logic [1:0]
   {
      smc_idle  = 2'd0,  // No access
      smc_le    = 2'd1,  // Leading edge wait
      smc_rw    = 2'd2,  // Strobes active
      smc_float = 2'd3   // Bus turnaround, response handoff
   } smc_state_e;

   // ------------------------------
   // Per access timing
   // ------------------------------
   typedef struct packed
   {
      logic [smc_edge_w-1:0] wele;   // LE cycles, 0 skips LE
      logic [smc_ws_w-1:0]   ws;     // RW lasts ws+1 cycles
      logic [smc_edge_w-1:0] oete;   // RW cycles before read strobe falls
   } smc_timing_t;

   // Request held in the input slot
   typedef struct packed
   {
      logic                  write;    // 1 for write
      logic [smc_addr_w-1:0] addr;
      logic [smc_data_w-1:0] wdata;
      logic [smc_be_w-1:0]   byte_en;  // Active high lanes
      smc_timing_t           timing;
   } smc_req_t;

   // Response returned through the output slot
   typedef struct packed
   {
      logic                  write;    // Direction echo
      logic [smc_data_w-1:0] rdata;    // Zero on writes
   } smc_resp_t;

endpackage

//--- smc_slot.sv
`timescale 1ns/100ps

// One entry holding buffer, valid/ready on both sides
module smc_slot #(
   parameter type payload_t = logic
) (
   input  logic     sys_clk30,
   input  logic     n_sys_reset30,
   input  logic     push,        // Offer from producer
   input  payload_t push_data,
   output logic     ready,       // Empty, push accepted
   output logic     valid,       // Entry held
   output payload_t data,
   input  logic     pop          // Consumer takes entry
);

   // Full slot never takes a push, even while popped
   assign ready = ~valid;

   // Occupancy flag
   always_ff @(posedge sys_clk30 or negedge n_sys_reset30)
   begin
      if (!n_sys_reset30)
         valid <= 1'b0;
      else if (push && !valid)
         valid <= 1'b1;          // Load when empty
      else if (pop)
         valid <= 1'b0;
   end

   // Payload storage
   always_ff @(posedge sys_clk30)
   begin
      if (push && !valid)
         data <= push_data;
   end

endmodule

//--- smc_wait_counter.sv
`timescale 1ns/100ps

// Phase timer for LE and RW
module smc_wait_counter (
   input  logic                        sys_clk30,
   input  logic                        n_sys_reset30,
   input  logic                        load,        // Phase start
   input  logic [smc_pkg::smc_ws_w-1:0] load_value,  // Cycles left minus one
   output logic                        expired      // Last cycle of phase
);
   import smc_pkg::*;

   logic [smc_ws_w-1:0] count;   // Remaining cycles

   // ------------------------------
   // Load or count down, stop at 0
   // ------------------------------
   always_ff @(posedge sys_clk30 or negedge n_sys_reset30)
   begin
      if (!n_sys_reset30)
         count <= '0;
      else if (load)
         count <= load_value;
      else if (count != '0)
         count <= count - 1'b1;
   end

   // Zero marks the final cycle of the current phase
   assign expired = (count == '0);

endmodule

//--- smc_access_fsm.sv
`timescale 1ns/100ps

// Access sequencer, IDLE -> LE -> RW -> FLOAT
module smc_access_fsm (
   input  logic                         sys_clk30,
   input  logic                         n_sys_reset30,
   input  logic                         head_valid,  // Input slot holds request
   input  smc_pkg::smc_req_t            head,
   output logic                         head_pop,
   input  logic                         resp_ready,  // Output slot empty
   output logic                         resp_push,
   output smc_pkg::smc_req_t            cur_req,     // Request being served
   output smc_pkg::smc_state_e          next_state,
   output logic                         load,        // Counter reload
   output logic [smc_pkg::smc_ws_w-1:0] load_value,
   input  logic                         expired
);
   import smc_pkg::*;

   smc_state_e state;   // Current access state
   smc_req_t   req_q;   // Request held for whole access

   // In IDLE the head is shown, so the registered strobes of the first
   // access cycle already see the new request
   assign cur_req = (state == smc_idle) ? head : req_q;

   // ------------------------------
   // Next state decode
   // ------------------------------
   always_comb
   begin
      next_state = state;
      head_pop   = 1'b0;
      resp_push  = 1'b0;
      load       = 1'b0;
      load_value = cur_req.timing.ws;   // RW phase length by default
      case (state)
         smc_idle:
         begin
            if (head_valid)
            begin
               head_pop = 1'b1;
               load     = 1'b1;
               if (head.timing.wele != '0)
               begin
                  next_state = smc_le;
                  load_value = smc_ws_w'(head.timing.wele - 1'b1);
               end
               else
                  next_state = smc_rw;   // No leading edge wait
            end
         end
         smc_le:
         begin
            if (expired)
            begin
               next_state = smc_rw;
               load       = 1'b1;        // Start RW timing
            end
         end
         smc_rw:
         begin
            if (expired)
               next_state = smc_float;
         end
         default:                      // FLOAT
         begin
            if (resp_ready)
            begin
               resp_push  = 1'b1;
               next_state = smc_idle;
            end                         // else hold, back-pressure
         end
      endcase
   end

   // State register
   always_ff @(posedge sys_clk30 or negedge n_sys_reset30)
   begin
      if (!n_sys_reset30)
         state <= smc_idle;
      else
         state <= next_state;
   end

   // Capture direction, address, data and timing at pop
   always_ff @(posedge sys_clk30)
   begin
      if (head_pop)
         req_q <= head;
   end

endmodule

//--- smc_strobe_gen.sv
`timescale 1ns/100ps

// External memory strobes, registered from next state
module smc_strobe_gen (
   input  logic                           sys_clk30,
   input  logic                           n_sys_reset30,
   input  smc_pkg::smc_state_e            next_state,
   input  smc_pkg::smc_req_t              cur_req,
   input  logic [smc_pkg::smc_data_w-1:0] mem_rdata,
   output logic                           n_mem_cs,   // Chip select
   output logic                           n_mem_rd,   // Read strobe
   output logic [smc_pkg::smc_be_w-1:0]   n_mem_we,   // Per lane write enables
   output logic                           n_mem_wr,   // Write strobe
   output logic                           n_ext_oe,   // Bus driver enable, reads
   output logic                           busy,
   output logic [smc_pkg::smc_data_w-1:0] rdata       // Captured read data
);
   import smc_pkg::*;

   smc_state_e          state_q;      // Mirrors FSM state register
   logic [smc_ws_w-1:0] rw_idx;       // Index of current RW cycle
   logic [smc_ws_w-1:0] rw_idx_nxt;   // Index of upcoming RW cycle
   logic                rw_nxt;       // Upcoming cycle is RW
   logic                rd_on;        // Read strobe low next cycle

   assign rw_nxt     = (next_state == smc_rw);
   assign rw_idx_nxt = (state_q == smc_rw) ? rw_idx + 1'b1 : '0;

   // Read strobe from index oete on, forced low on the last RW cycle
   assign rd_on = rw_nxt & ~cur_req.write &
                  ((rw_idx_nxt >= cur_req.timing.oete) |
                   (rw_idx_nxt == cur_req.timing.ws));

   // ------------------------------
   // Strobe registers
   // ------------------------------
   always_ff @(posedge sys_clk30 or negedge n_sys_reset30)
   begin
      if (!n_sys_reset30)
      begin
         state_q  <= smc_idle;
         rw_idx   <= '0;
         n_mem_cs <= 1'b1;
         n_mem_rd <= 1'b1;
         n_mem_we <= '1;
         n_mem_wr <= 1'b1;
         n_ext_oe <= 1'b1;
         busy     <= 1'b0;
      end
      else
      begin
         state_q  <= next_state;
         if (rw_nxt)
            rw_idx <= rw_idx_nxt;
         n_mem_cs <= ~((next_state == smc_le) | rw_nxt);
         n_mem_rd <= ~rd_on;
         n_mem_we <= (rw_nxt & cur_req.write) ? ~cur_req.byte_en : '1;
         n_mem_wr <= ~(rw_nxt & cur_req.write);  // Full cycle, every RW cycle
         n_ext_oe <= ~(rw_nxt & ~cur_req.write);
         busy     <= (next_state != smc_idle);
      end
   end

   // Sample bus on the edge ending the last RW cycle
   always_ff @(posedge sys_clk30)
   begin
      if ((state_q == smc_rw) && !rw_nxt)
         rdata <= cur_req.write ? '0 : mem_rdata;
   end

endmodule

//--- smc_top.sv
`timescale 1ns/100ps

// Static memory controller access engine, single bank
module smc_top (
   input  logic                           sys_clk30,
   input  logic                           n_sys_reset30,
   // Request port
   input  smc_pkg::smc_req_t              req,
   input  logic                           req_valid,
   output logic                           req_ready,
   // Response port
   output smc_pkg::smc_resp_t             resp,
   output logic                           resp_valid,
   input  logic                           resp_ready,
   // Memory pins
   output logic [smc_pkg::smc_addr_w-1:0] mem_addr,
   output logic [smc_pkg::smc_data_w-1:0] mem_wdata,
   input  logic [smc_pkg::smc_data_w-1:0] mem_rdata,
   output logic                           n_mem_cs,
   output logic                           n_mem_rd,
   output logic [smc_pkg::smc_be_w-1:0]   n_mem_we,
   output logic                           n_mem_wr,
   output logic                           n_ext_oe,
   output logic                           busy
);
   import smc_pkg::*;

   // ------------------------------
   // Internal nets
   // ------------------------------
   logic                  head_valid;
   smc_req_t              head;
   logic                  head_pop;
   logic                  out_ready;    // Output slot free
   logic                  resp_push;
   smc_resp_t             resp_data;
   smc_req_t              cur_req;
   smc_state_e            next_state;
   logic                  load;
   logic [smc_ws_w-1:0]   load_value;
   logic                  expired;
   logic [smc_data_w-1:0] rdata;

   assign mem_addr  = cur_req.addr;
   assign mem_wdata = cur_req.wdata;
   assign resp_data = '{write: cur_req.write, rdata: rdata};

   // Input slot, lets one request wait behind a running access
   smc_slot #(.payload_t(smc_req_t)) u_req_slot (
      .sys_clk30(sys_clk30), .n_sys_reset30(n_sys_reset30),
      .push(req_valid), .push_data(req), .ready(req_ready),
      .valid(head_valid), .data(head), .pop(head_pop)
   );

   // Output slot, holds response under back-pressure
   smc_slot #(.payload_t(smc_resp_t)) u_resp_slot (
      .sys_clk30(sys_clk30), .n_sys_reset30(n_sys_reset30),
      .push(resp_push), .push_data(resp_data), .ready(out_ready),
      .valid(resp_valid), .data(resp), .pop(resp_ready)
   );

   smc_access_fsm u_fsm (
      .sys_clk30(sys_clk30), .n_sys_reset30(n_sys_reset30),
      .head_valid(head_valid), .head(head), .head_pop(head_pop),
      .resp_ready(out_ready), .resp_push(resp_push), .cur_req(cur_req),
      .next_state(next_state), .load(load), .load_value(load_value),
      .expired(expired)
   );

   smc_wait_counter u_wait (
      .sys_clk30(sys_clk30), .n_sys_reset30(n_sys_reset30),
      .load(load), .load_value(load_value), .expired(expired)
   );

   smc_strobe_gen u_strobe (
      .sys_clk30(sys_clk30), .n_sys_reset30(n_sys_reset30),
      .next_state(next_state), .cur_req(cur_req), .mem_rdata(mem_rdata),
      .n_mem_cs(n_mem_cs), .n_mem_rd(n_mem_rd), .n_mem_we(n_mem_we),
      .n_mem_wr(n_mem_wr), .n_ext_oe(n_ext_oe), .busy(busy), .rdata(rdata)
   );

endmodule

//--- tb_smc_top.sv
`timescale 1ns/100ps

module tb_smc_top;
   import smc_pkg::*;

   // Expected response plus low-cycle counts of one access
   typedef struct packed
   {
      smc_resp_t   resp;
      logic [15:0] cs;
      logic [15:0] oe;
      logic [15:0] rd;
      logic [15:0] wr;
   } expect_t;

   logic                  sys_clk30 = 1'b0;
   logic                  n_sys_reset30;
   smc_req_t              req;
   logic                  req_valid;
   logic                  req_ready;
   smc_resp_t             resp;
   logic                  resp_valid;
   logic                  resp_ready = 1'b0;
   logic [smc_addr_w-1:0] mem_addr;
   logic [smc_data_w-1:0] mem_wdata;
   logic [smc_data_w-1:0] mem_rdata;
   logic                  n_mem_cs;
   logic                  n_mem_rd;
   logic [smc_be_w-1:0]   n_mem_we;
   logic                  n_mem_wr;
   logic                  n_ext_oe;
   logic                  busy;

   smc_req_t    strobe_q[$];           // Accepted with strobes not yet seen
   smc_req_t    resp_q[$];             // Accepted with response not yet taken
   expect_t     held;                  // Expected response parked under back-pressure
   logic [1:0]  ready_mode = 2'd0;     // 0 high, 1 low, 2 random
   logic [15:0] cs_cnt = '0;
   logic [15:0] oe_cnt = '0;
   logic [15:0] rd_cnt = '0;
   logic [15:0] wr_cnt = '0;
   logic        accept_busy;           // busy seen at last acceptance
   int          checks = 0;
   int          errors = 0;
   int          test_errs;

   smc_top UUT (.*);

   always #4 sys_clk30 = ~sys_clk30;   // 8 ns period

   // ------------------------------
   // Memory model and reference
   // ------------------------------
   function automatic logic [31:0] mem_word(logic [15:0] a);
      return {a ^ 16'hA5C3, ~a} + {a[7:0], a[15:8], 16'h1D2B};   // Mixes every address bit
   endfunction

   assign mem_rdata = mem_word(mem_addr);

   function automatic expect_t expected_for(smc_req_t r);
      expect_t     e;
      logic [15:0] rw_cycles;
      logic [15:0] delay;
      rw_cycles = 16'(r.timing.ws) + 16'd1;
      // Read strobe always falls by the last RW cycle
      delay = (16'(r.timing.oete) < 16'(r.timing.ws)) ? 16'(r.timing.oete) : 16'(r.timing.ws);
      e.resp.write = r.write;
      e.resp.rdata = r.write ? '0 : mem_word(r.addr);
      e.cs = 16'(r.timing.wele) + rw_cycles;   // LE plus RW
      e.oe = r.write ? 16'd0 : rw_cycles;
      e.rd = r.write ? 16'd0 : rw_cycles - delay;
      e.wr = r.write ? rw_cycles : 16'd0;
      return e;
   endfunction

   task automatic check_val(string name, logic [63:0] got, logic [63:0] exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("error %s: got %h expected %h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic give_up(string why);
      $display("%s at %0t", why, $time);
      $display("TEST RESULT: FAIL");
      $finish;
   endtask

   function automatic smc_req_t make_req(logic w, logic [15:0] a, logic [31:0] d,
                                         logic [3:0] be, logic [1:0] wele,
                                         logic [7:0] ws, logic [1:0] oete);
      smc_req_t r;
      r.write       = w;
      r.addr        = a;
      r.wdata       = d;
      r.byte_en     = be;
      r.timing.wele = wele;
      r.timing.ws   = ws;
      r.timing.oete = oete;
      return r;
   endfunction

   function automatic smc_req_t random_req();
      return make_req(1'($urandom), 16'($urandom), $urandom, 4'($urandom),
                      2'($urandom), 8'($urandom_range(0, 5)), 2'($urandom));
   endfunction

   // ------------------------------
   // Request driver
   // ------------------------------
   task automatic offer_req(smc_req_t r);
      @(posedge sys_clk30);
      req       <= r;
      req_valid <= 1'b1;
   endtask

   task automatic wait_accept();
      int n;
      n = 0;
      @(negedge sys_clk30);
      while (!req_ready)
      begin
         n++;
         if (n > 200)
            give_up("request was not accepted within 200 cycles");
         @(negedge sys_clk30);
      end
      accept_busy = busy;
      @(posedge sys_clk30);              // Transfer edge
      req_valid <= 1'b0;
      strobe_q.push_back(req);
      resp_q.push_back(req);
   endtask

   task automatic send_req(smc_req_t r);
      offer_req(r);
      wait_accept();
   endtask

   // All accesses finished and every response taken
   task automatic wait_drain();
      int n;
      n = 0;
      @(negedge sys_clk30);
      while (strobe_q.size() != 0 || resp_q.size() != 0 || busy || resp_valid)
      begin
         n++;
         if (n > 1000)
            give_up("outstanding accesses did not drain within 1000 cycles");
         @(negedge sys_clk30);
      end
   endtask

   task automatic end_test(string name);
      $display("test %s finished, %0d errors", name, errors - test_errs);
   endtask

   always @(posedge sys_clk30)
   begin
      case (ready_mode)
         2'd0:    resp_ready <= 1'b1;
         2'd1:    resp_ready <= 1'b0;
         default: resp_ready <= ($urandom_range(0, 3) != 0);   // Ready 3 cycles in 4
      endcase
   end

   // ------------------------------
   // Monitor sampling on the falling edge
   // ------------------------------
   always @(negedge sys_clk30)
   begin
      expect_t             e;
      logic [smc_be_w-1:0] we_exp;
      if (n_sys_reset30 && !n_mem_cs && strobe_q.size() == 0)
         give_up("chip select went low with no request outstanding");
      else if (n_sys_reset30 && !n_mem_cs)
      begin
         cs_cnt = cs_cnt + 16'd1;
         if (!n_ext_oe)
            oe_cnt = oe_cnt + 16'd1;
         if (!n_mem_rd)
            rd_cnt = rd_cnt + 16'd1;
         check_val("mem_addr", mem_addr, strobe_q[0].addr);
         we_exp = ~strobe_q[0].byte_en;
         if (!n_mem_wr)
         begin
            wr_cnt = wr_cnt + 16'd1;
            check_val("n_mem_we", n_mem_we, we_exp);
            check_val("mem_wdata", mem_wdata, strobe_q[0].wdata);
         end
         else
            check_val("n_mem_we", n_mem_we, 4'hf);   // No lane outside the write strobe
      end
      else if (n_sys_reset30)
      begin
         check_val("idle_strobes", {n_mem_rd, n_mem_wr, n_ext_oe, n_mem_we}, 7'h7f);
         if (cs_cnt != 0)                  // Chip select just rose so the access is over
         begin
            e = expected_for(strobe_q.pop_front());
            check_val("n_mem_cs_cycles", cs_cnt, e.cs);
            check_val("n_ext_oe_cycles", oe_cnt, e.oe);
            check_val("n_mem_rd_cycles", rd_cnt, e.rd);
            check_val("n_mem_wr_cycles", wr_cnt, e.wr);
            cs_cnt = '0;
            oe_cnt = '0;
            rd_cnt = '0;
            wr_cnt = '0;
         end
      end
      // Handshake completes on the next rising edge
      if (n_sys_reset30 && resp_valid && resp_ready && resp_q.size() == 0)
         give_up("response returned with no request outstanding");
      else if (n_sys_reset30 && resp_valid && resp_ready)
      begin
         e = expected_for(resp_q.pop_front());
         check_val("resp", resp, e.resp);
      end
   end

   // ------------------------------
   // Test sequence
   // ------------------------------
   initial
   begin
      void'($urandom(54721));
      n_sys_reset30 = 1'b0;
      req           = '0;
      req_valid     = 1'b0;
      repeat (5) @(posedge sys_clk30);
      n_sys_reset30 <= 1'b1;

      test_errs = errors;
      @(negedge sys_clk30);
      check_val("req_ready_resp_valid_busy", {req_ready, resp_valid, busy}, 3'b100);
      check_val("reset_strobes", {n_mem_cs, n_mem_rd, n_mem_wr, n_ext_oe, n_mem_we}, 8'hff);
      end_test("reset_state");

      test_errs = errors;
      send_req(make_req(1'b0, 16'h1234, '0, 4'hf, 2'd2, 8'd3, 2'd1));
      wait_drain();
      send_req(make_req(1'b0, 16'hbeef, '0, 4'hf, 2'd0, 8'd0, 2'd2));
      wait_drain();
      send_req(make_req(1'b0, 16'h0f0f, '0, 4'hf, 2'd1, 8'd2, 2'd3));
      wait_drain();
      end_test("read_access");

      test_errs = errors;
      send_req(make_req(1'b1, 16'h4000, 32'hcafe_f00d, 4'b1010, 2'd1, 8'd2, 2'd0));
      wait_drain();
      send_req(make_req(1'b1, 16'h8ffe, 32'h0123_4567, 4'b0111, 2'd0, 8'd4, 2'd3));
      wait_drain();
      end_test("write_access");

      test_errs = errors;
      send_req(make_req(1'b0, 16'h2222, '0, 4'hf, 2'd1, 8'd3, 2'd0));
      send_req(make_req(1'b1, 16'h3333, 32'h5555_aaaa, 4'b1100, 2'd2, 8'd1, 2'd1));
      check_val("busy_at_accept", accept_busy, 1'b1);
      send_req(make_req(1'b0, 16'h4444, '0, 4'hf, 2'd0, 8'd2, 2'd2));
      wait_drain();
      end_test("back_to_back");

      // Output slot full with one access stuck in FLOAT and one request parked
      test_errs = errors;
      ready_mode = 2'd1;
      send_req(make_req(1'b0, 16'h5a5a, '0, 4'hf, 2'd1, 8'd1, 2'd0));
      send_req(make_req(1'b1, 16'h6b6b, 32'h1111_2222, 4'b0011, 2'd0, 8'd2, 2'd0));
      send_req(make_req(1'b0, 16'h7c7c, '0, 4'hf, 2'd2, 8'd0, 2'd1));
      @(negedge sys_clk30);
      check_val("resp_valid", resp_valid, 1'b1);
      held = expected_for(resp_q[0]);
      offer_req(make_req(1'b1, 16'h8d8d, 32'h3333_4444, 4'b1111, 2'd1, 8'd1, 2'd0));
      // Second access finishes RW and then waits in FLOAT
      repeat (30)
      begin
         @(negedge sys_clk30);
         check_val("resp_valid", resp_valid, 1'b1);
         check_val("resp", resp, held.resp);
         check_val("req_ready", req_ready, 1'b0);
         check_val("busy", busy, 1'b1);
      end
      ready_mode = 2'd0;
      wait_accept();
      wait_drain();
      end_test("back_pressure");

      test_errs = errors;
      ready_mode = 2'd2;
      for (int i = 0; i < 40; i++)
      begin
         send_req(random_req());
         repeat ($urandom_range(0, 2)) @(posedge sys_clk30);   // Random request gaps
      end
      wait_drain();
      ready_mode = 2'd0;
      end_test("random_mix");

      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0)
         $display("TEST RESULT: PASS");
      else
         $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule

//--- flist.f
smc_pkg.sv
smc_slot.sv
smc_wait_counter.sv
smc_access_fsm.sv
smc_strobe_gen.sv
smc_top.sv
tb_smc_top.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the SMC testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing -Wno-fatal -f flist.f --top-module tb_smc_top \
      -o sim_tb > build.log 2>&1; then
   cat build.log
   echo "Verilator build failed"
   exit 1
fi

if ! ./obj_dir/sim_tb > "$LOG" 2>&1; then
   cat "$LOG"
   echo "Simulation exited with an error"
   exit 1
fi

cat "$LOG"

if grep -q "TEST RESULT: FAIL" "$LOG"; then
   exit 1
fi
exit 0
